//--- logic/game_rom_pkg.sv
package game_rom_pkg;

    // SDRAM read port geometry
    localparam int unsigned sdram_aw = 22;   // Word address width
    localparam int unsigned sdram_dw = 32;   // Read word width

    // Slots served by the arbiter
    // 0 main CPU, 1 sound CPU, 2 graphics
    localparam int unsigned slot_count = 3;

    // Word base address of each slot region in SDRAM
    localparam logic [sdram_aw-1:0] main_offset = 22'h0_0000;
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h1_8000;
    localparam logic [sdram_aw-1:0] gfx_offset  = 22'h2_0000;

    // Download bytes from here on go to the PROMs, not to SDRAM
    localparam logic [24:0] prom_start = 25'hC_0000;

    // First byte of the alternate title
    // Both of its ROM sets begin with this value
    localparam logic [7:0] title_byte = 8'h7e;

endpackage

//--- logic/rom_dwnld.sv
module rom_dwnld #(
    parameter logic [24:0] PROM_START = game_rom_pkg::prom_start
) (
    input  logic                              clk,
    input  logic                              rst24,
    input  logic                              downloading,
    input  logic [24:0]                       ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    output logic [game_rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [15:0]                       prog_data,
    output logic [1:0]                        prog_mask,   // Active low
    output logic                              prog_we,
    output logic                              prom_we,
    output logic                              title_alt
);

    logic wr_en;
    logic is_prom;

    assign wr_en   = ioctl_wr && downloading;
    assign is_prom = ioctl_addr >= PROM_START;

    // Strobes and title flag
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            prog_we   <= 1'b0;
            prom_we   <= 1'b0;
            title_alt <= 1'b0;
        end else begin
            prog_we <= wr_en && !is_prom;
            prom_we <= wr_en && is_prom;
            // Only the very first byte decides the title
            if (wr_en && ioctl_addr == 25'd0) begin
                title_alt <= ioctl_dout == game_rom_pkg::title_byte;
            end
        end
    end

    // Write payload, one SDRAM half word per byte
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_addr <= ioctl_addr[game_rom_pkg::sdram_aw:1];
            prog_data <= {2{ioctl_dout}};              // Same byte on both lanes
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10; // Odd byte goes high
        end
    end

endmodule

//--- logic/rom_slot.sv
module rom_slot #(
    parameter int                                AW     = 18,
    parameter logic [game_rom_pkg::sdram_aw-1:0] OFFSET = '0,
    parameter type                               data_t = logic [7:0]
) (
    input  logic                              clk,
    input  logic                              rst24,
    input  logic                              downloading,
    input  logic                              cs,
    input  logic [AW-1:0]                     addr,
    input  logic                              prefetch,
    input  logic                              fill,
    input  logic [game_rom_pkg::sdram_dw-1:0] fill_data,
    output logic                              ok,
    output data_t                             data,
    output logic                              req,
    output logic [game_rom_pkg::sdram_aw-1:0] sdram_addr
);

    localparam int dw    = $bits(data_t);
    localparam int shift = $clog2(game_rom_pkg::sdram_dw / dw); // Address bits inside a word

    typedef logic [game_rom_pkg::sdram_aw-1:0] word_addr_t;

    logic [game_rom_pkg::sdram_dw-1:0] cache_word;
    logic [AW-1:0] word_idx;
    logic [AW-1:0] tag;
    logic [AW-1:0] pend_tag;   // Word asked for by the pending request
    logic [AW-1:0] addr_l;
    logic          valid;
    logic          cs_l;
    logic          hit;
    logic          moved;
    logic          need;

    assign word_idx = addr >> shift;
    assign hit      = valid && tag == word_idx;
    assign moved    = cs_l && addr != addr_l;  // CPU jumped while selecting
    assign need     = (cs || prefetch) && !hit && !req && !downloading;

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            valid <= 1'b0;
            req   <= 1'b0;
            ok    <= 1'b0;
            cs_l  <= 1'b0;
        end else begin
            cs_l <= cs;
            ok   <= cs && hit && !moved && !downloading;
            if (downloading) begin
                // Contents are being rewritten
                valid <= 1'b0;
                req   <= 1'b0;
            end else if (fill && req) begin
                valid <= 1'b1;
                req   <= 1'b0;
            end else if (need) begin
                req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_l <= addr;
        if (need) begin
            pend_tag   <= word_idx;
            sdram_addr <= OFFSET + word_addr_t'(word_idx);
        end
        if (fill && req) begin
            cache_word <= fill_data;
            tag        <= pend_tag;
        end
    end

    // Byte 0 sits in the low bits of the word
    generate
        if (shift == 0) begin : g_wide
            assign data = data_t'(cache_word);
        end else begin : g_narrow
            assign data = data_t'(cache_word >> (dw * addr[shift-1:0]));
        end
    endgenerate

endmodule

//--- logic/rom_arbiter.sv
module rom_arbiter (
    input  logic                                clk,
    input  logic                                rst24,
    input  logic                                downloading,
    input  logic [game_rom_pkg::slot_count-1:0] req,
    input  logic [game_rom_pkg::sdram_aw-1:0]   slot0_addr,
    input  logic [game_rom_pkg::sdram_aw-1:0]   slot1_addr,
    input  logic [game_rom_pkg::sdram_aw-1:0]   slot2_addr,
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    output logic [game_rom_pkg::slot_count-1:0] fill,
    output logic                                sdram_req,
    output logic [game_rom_pkg::sdram_aw-1:0]   sdram_addr,
    output logic [1:0]                          prefetch,
    output logic                                cpu_start
);

    typedef enum logic [1:0] {
        idle,
        wait_ack,
        wait_data
    } state_t;

    state_t state;

    logic [game_rom_pkg::slot_count-1:0] grant;
    logic [game_rom_pkg::slot_count-1:0] pick;
    logic [game_rom_pkg::sdram_aw-1:0]   slot_addr [game_rom_pkg::slot_count];
    logic [game_rom_pkg::sdram_aw-1:0]   pick_addr;
    logic [1:0]                          boot_fill;  // CPU slots filled since download
    logic                                stale;      // Read overlapped a download
    logic                                grant_now;

    assign slot_addr[0] = slot0_addr;
    assign slot_addr[1] = slot1_addr;
    assign slot_addr[2] = slot2_addr;

    // Lowest index wins
    always_comb begin
        pick      = '0;
        pick_addr = slot0_addr;
        for (int i = game_rom_pkg::slot_count - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick      = '0;
                pick[i]   = 1'b1;
                pick_addr = slot_addr[i];
            end
        end
    end

    assign grant_now = state == idle && !downloading && |req;

    // Slot samples data_read in the same cycle as data_rdy
    assign fill = (state == wait_data && data_rdy && !stale && !downloading) ? grant : '0;

    // Keep both CPU slots loaded until the CPUs may run
    assign prefetch = {2{~cpu_start}};

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            state     <= idle;
            sdram_req <= 1'b0;
            grant     <= '0;
            stale     <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (grant_now) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        stale     <= 1'b0;
                        state     <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= wait_data;
                    end
                end
                wait_data: if (data_rdy) state <= idle;
                default: state <= idle;
            endcase
            if (downloading && state != idle) stale <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_now) sdram_addr <= pick_addr;  // Held through the read
    end

    // CPU start after both program ROMs are in
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            boot_fill <= 2'b00;
            cpu_start <= 1'b0;
        end else if (downloading) begin
            boot_fill <= 2'b00;
            cpu_start <= 1'b0;
        end else begin
            boot_fill <= boot_fill | fill[1:0];
            cpu_start <= &boot_fill;
        end
    end

endmodule

//--- logic/game_rom_top.sv
module game_rom_top #(
    parameter logic [24:0] PROM_START = game_rom_pkg::prom_start
) (
    input  logic                              clk,
    input  logic                              rst24,
    input  logic                              downloading,
    // ROM download
    input  logic [24:0]                       ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    output logic [game_rom_pkg::sdram_aw-1:0] prog_addr,
    output logic [15:0]                       prog_data,
    output logic [1:0]                        prog_mask,
    output logic                              prog_we,
    output logic                              prom_we,
    output logic                              title_alt,
    // Main CPU ROM
    input  logic                              main_cs,
    input  logic [17:0]                       main_addr,
    output logic                              main_ok,
    output logic [7:0]                        main_data,
    // Sound CPU ROM
    input  logic                              snd_cs,
    input  logic [14:0]                       snd_addr,
    output logic                              snd_ok,
    output logic [7:0]                        snd_data,
    // Graphics ROM
    input  logic                              gfx_cs,
    input  logic [17:0]                       gfx_addr,
    output logic                              gfx_ok,
    output logic [31:0]                       gfx_data,
    // SDRAM read port
    output logic                              sdram_req,
    output logic [game_rom_pkg::sdram_aw-1:0] sdram_addr,
    input  logic                              sdram_ack,
    input  logic                              data_rdy,
    input  logic [game_rom_pkg::sdram_dw-1:0] data_read,
    output logic                              cpu_start
);

    localparam int main_aw = 18;
    localparam int snd_aw  = 15;
    localparam int gfx_aw  = 18;

    logic [game_rom_pkg::slot_count-1:0] slot_req;
    logic [game_rom_pkg::slot_count-1:0] slot_fill;
    logic [game_rom_pkg::sdram_aw-1:0]   main_sdram_addr;
    logic [game_rom_pkg::sdram_aw-1:0]   snd_sdram_addr;
    logic [game_rom_pkg::sdram_aw-1:0]   gfx_sdram_addr;
    logic [1:0]                          prefetch;

    rom_dwnld #(.PROM_START(PROM_START)) u_dwnld (
        .clk         ( clk         ),
        .rst24       ( rst24       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .title_alt   ( title_alt   )
    );

    rom_slot #(
        .AW     ( main_aw                  ),
        .OFFSET ( game_rom_pkg::main_offset ),
        .data_t ( logic [7:0]              )
    ) u_main (
        .clk         ( clk             ),
        .rst24       ( rst24           ),
        .downloading ( downloading     ),
        .cs          ( main_cs         ),
        .addr        ( main_addr       ),
        .prefetch    ( prefetch[0]     ),  // Boot load
        .fill        ( slot_fill[0]    ),
        .fill_data   ( data_read       ),
        .ok          ( main_ok         ),
        .data        ( main_data       ),
        .req         ( slot_req[0]     ),
        .sdram_addr  ( main_sdram_addr )
    );

    rom_slot #(
        .AW     ( snd_aw                   ),
        .OFFSET ( game_rom_pkg::snd_offset ),
        .data_t ( logic [7:0]              )
    ) u_snd (
        .clk         ( clk            ),
        .rst24       ( rst24          ),
        .downloading ( downloading    ),
        .cs          ( snd_cs         ),
        .addr        ( snd_addr       ),
        .prefetch    ( prefetch[1]    ),  // Boot load
        .fill        ( slot_fill[1]   ),
        .fill_data   ( data_read      ),
        .ok          ( snd_ok         ),
        .data        ( snd_data       ),
        .req         ( slot_req[1]    ),
        .sdram_addr  ( snd_sdram_addr )
    );

    // Graphics is only read on demand
    rom_slot #(
        .AW     ( gfx_aw                   ),
        .OFFSET ( game_rom_pkg::gfx_offset ),
        .data_t ( logic [31:0]             )
    ) u_gfx (
        .clk         ( clk            ),
        .rst24       ( rst24          ),
        .downloading ( downloading    ),
        .cs          ( gfx_cs         ),
        .addr        ( gfx_addr       ),
        .prefetch    ( 1'b0           ),
        .fill        ( slot_fill[2]   ),
        .fill_data   ( data_read      ),
        .ok          ( gfx_ok         ),
        .data        ( gfx_data       ),
        .req         ( slot_req[2]    ),
        .sdram_addr  ( gfx_sdram_addr )
    );

    rom_arbiter u_arbiter (
        .clk         ( clk             ),
        .rst24       ( rst24           ),
        .downloading ( downloading     ),
        .req         ( slot_req        ),
        .slot0_addr  ( main_sdram_addr ),
        .slot1_addr  ( snd_sdram_addr  ),
        .slot2_addr  ( gfx_sdram_addr  ),
        .sdram_ack   ( sdram_ack       ),
        .data_rdy    ( data_rdy        ),
        .fill        ( slot_fill       ),
        .sdram_req   ( sdram_req       ),
        .sdram_addr  ( sdram_addr      ),
        .prefetch    ( prefetch        ),
        .cpu_start   ( cpu_start       )
    );

endmodule

//--- dv/sdram_model.sv
module sdram_model (
    input  logic        clk,
    input  logic        rst24,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    integer      seed = 55;
    logic [1:0]  phase;   // 0 idle, 1 ack delay, 2 data delay, 3 data out
    logic [2:0]  count;
    logic [21:0] addr_l;

    always @(posedge clk or posedge rst24) begin
        if (rst24) begin
            phase     <= 2'd0;
            count     <= 3'd0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            case (phase)
                2'd0: if (sdram_req) begin
                    addr_l <= sdram_addr;
                    count  <= 3'(($random(seed) & 3) + 1);  // Ack after 1 to 4 cycles
                    phase  <= 2'd1;
                end
                2'd1: if (count == 3'd1) begin
                    sdram_ack <= 1'b1;
                    count     <= 3'd2;
                    phase     <= 2'd2;
                end else begin
                    count <= count - 3'd1;
                end
                2'd2: if (count == 3'd1) begin
                    data_rdy  <= 1'b1;
                    data_read <= {8'hc3, addr_l[7:0] ^ 8'h5a, addr_l[15:8], addr_l[7:0]};
                    phase     <= 2'd3;
                end else begin
                    count <= count - 3'd1;
                end
                default: phase <= 2'd0;
            endcase
        end
    end

endmodule

//--- dv/tb_game_rom.sv
module tb_game_rom;

    localparam int timeout = 200;

    typedef struct packed {
        logic [24:0] addr;
        logic [7:0]  data;
        logic        prom;   // Strobe lands on prom_we
        logic [1:0]  mask;   // Active low lane mask
    } write_t;

    typedef struct packed {
        logic [1:0]  slot;
        logic [17:0] addr;
        logic [3:0]  gap;   // Idle cycles before the next read
    } read_t;

    // First download with two PROM bytes
    write_t writes [5] = '{
        '{25'd0, game_rom_pkg::title_byte, 1'b0, 2'b10},
        '{25'd1, 8'h34, 1'b0, 2'b01},
        '{25'h1_2345, 8'ha7, 1'b0, 2'b01},
        '{game_rom_pkg::prom_start, 8'h0f, 1'b1, 2'b10},
        '{game_rom_pkg::prom_start + 25'd3, 8'hf0, 1'b1, 2'b01}
    };

    // Ordinary first byte of the second download
    write_t second_write = '{25'd0, 8'h12, 1'b0, 2'b10};

    // Slot reads
    // The second and last entries repeat a cached word
    read_t reads [7] = '{
        '{2'd0, 18'h0_0011, 4'd2},
        '{2'd0, 18'h0_0012, 4'd1},
        '{2'd1, 18'h0_0123, 4'd3},
        '{2'd2, 18'h0_0456, 4'd1},
        '{2'd0, 18'h3_ff00, 4'd2},
        '{2'd1, 18'h0_7ffe, 4'd1},
        '{2'd2, 18'h0_0456, 4'd2}
    };

    logic        clk = 1'b0;
    logic        rst24;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prom_we;
    logic        title_alt;
    logic [2:0]  cs_vec;     // gfx, snd, main
    logic [17:0] main_addr;
    logic [14:0] snd_addr;
    logic [17:0] gfx_addr;
    logic        main_ok;
    logic        snd_ok;
    logic        gfx_ok;
    logic [7:0]  main_data;
    logic [7:0]  snd_data;
    logic [31:0] gfx_data;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    logic [31:0] data_read;
    logic        cpu_start;

    wire       main_cs = cs_vec[0];
    wire       snd_cs  = cs_vec[1];
    wire       gfx_cs  = cs_vec[2];
    wire [2:0] ok_vec  = {gfx_ok, snd_ok, main_ok};

    game_rom_top #(.PROM_START(game_rom_pkg::prom_start)) i_dut (.*);

    sdram_model i_sdram (.*);

    always #50 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // Bytes low to high are A[7:0], A[15:8], A[7:0] ^ 5a and c3
    function automatic logic [31:0] rule_word(input logic [21:0] a);
        return {8'hc3, a[7:0] ^ 8'h5a, a[15:8], a[7:0]};
    endfunction

    // SDRAM word holding a slot address
    function automatic logic [21:0] word_addr(input int slot, input logic [17:0] a);
        case (slot)
            0: return game_rom_pkg::main_offset + 22'(a >> 2);  // Four bytes per word
            1: return game_rom_pkg::snd_offset + 22'(a >> 2);
            default: return game_rom_pkg::gfx_offset + 22'(a);
        endcase
    endfunction

    function automatic logic [31:0] expected(input int slot, input logic [17:0] a);
        logic [31:0] w;
        w = rule_word(word_addr(slot, a));
        if (slot == 2) return w;
        return {24'd0, w[8*a[1:0] +: 8]};
    endfunction

    function automatic logic [31:0] slot_data(input int slot);
        case (slot)
            0: return {24'd0, main_data};
            1: return {24'd0, snd_data};
            default: return gfx_data;
        endcase
    endfunction

    // Address the CPU side currently drives on a slot
    function automatic logic [17:0] cpu_addr(input int slot);
        case (slot)
            0: return main_addr;
            1: return {3'd0, snd_addr};
            default: return gfx_addr;
        endcase
    endfunction

    task automatic check_slot(input int slot, input logic [17:0] a);
        check_eq($sformatf("slot %0d data at %h", slot, a), slot_data(slot), expected(slot, a));
    endtask

    // A request may only carry the word of a slot being read
    task automatic check_request(input logic [2:0] which);
        logic known;
        known = 1'b0;
        for (int s = 0; s < 3; s++) begin
            if (which[s] && sdram_addr == word_addr(s, cpu_addr(s))) known = 1'b1;
        end
        assert (known) else
            stop_run($sformatf("MISMATCH at %0t: sdram_addr %h is no word of slots %b",
                               $time, sdram_addr, which));
    endtask

    task automatic set_addr(input int slot, input logic [17:0] a);
        case (slot)
            0: main_addr <= a;
            1: snd_addr <= a[14:0];
            default: gfx_addr <= a;
        endcase
    endtask

    // One download byte whose strobe must follow one cycle later
    task automatic write_byte(input write_t w);
        @(posedge clk);
        ioctl_addr <= w.addr;
        ioctl_dout <= w.data;
        ioctl_wr   <= 1'b1;
        @(negedge clk);
        check_eq("strobes before write", {prog_we, prom_we}, 2'b00);
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        check_eq("write strobes", {prog_we, prom_we}, {!w.prom, w.prom});
        check_eq("prog_addr", prog_addr, w.addr >> 1);
        check_eq("prog_data", prog_data, {w.data, w.data});
        check_eq("prog_mask", prog_mask, w.mask);
        if (w.addr == 25'd0) begin
            check_eq("title_alt", title_alt, w.data == game_rom_pkg::title_byte);
        end
        @(negedge clk);
        check_eq("strobes after write", {prog_we, prom_we}, 2'b00);
    endtask

    task automatic wait_ok(input logic [2:0] which);
        int n;
        n = 0;
        @(negedge clk);
        while ((ok_vec & which) != which) begin
            assert (n < timeout) else
                stop_run($sformatf("Timed out waiting for ok, slots %b", which));
            if (sdram_req) check_request(which);
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_start();
        int n;
        n = 0;
        @(negedge clk);
        while (!cpu_start) begin
            assert (n < timeout) else stop_run("Timed out waiting for cpu_start to rise");
            if (sdram_req) check_request(3'b011);  // Boot loads of the CPU slots
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_released();
        int n;
        n = 0;
        @(negedge clk);
        while (ok_vec != 3'b000 || cpu_start) begin
            assert (n < timeout) else stop_run("ok or cpu_start stayed high during download");
            n++;
            @(negedge clk);
        end
    endtask

    initial begin
        rst24       = 1'b1;
        downloading = 1'b1;  // Core powers up loading
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        cs_vec      = '0;
        main_addr   = '0;
        snd_addr    = '0;
        gfx_addr    = '0;
        repeat (3) @(posedge clk);
        rst24 <= 1'b0;

        for (int i = 0; i < $size(writes); i++) begin
            write_byte(writes[i]);
        end
        @(posedge clk);
        downloading <= 1'b0;
        wait_start();        // Both CPU slots prefetched

        for (int i = 0; i < $size(reads); i++) begin
            @(posedge clk);
            set_addr(reads[i].slot, reads[i].addr);
            cs_vec[reads[i].slot] <= 1'b1;
            wait_ok(3'b001 << reads[i].slot);
            check_slot(reads[i].slot, reads[i].addr);
            @(posedge clk);
            cs_vec <= '0;
            repeat (reads[i].gap) @(posedge clk);
        end

        // All three slots miss at once
        @(posedge clk);
        set_addr(0, 18'h2_0005);
        set_addr(1, 18'h0_0042);
        set_addr(2, 18'h1_2345);
        cs_vec <= 3'b111;
        wait_ok(3'b111);
        check_slot(0, 18'h2_0005);
        check_slot(1, 18'h0_0042);
        check_slot(2, 18'h1_2345);

        // Second download with an ordinary first byte
        @(posedge clk);
        downloading <= 1'b1;
        wait_released();
        write_byte(second_write);
        @(posedge clk);
        cs_vec      <= '0;
        downloading <= 1'b0;
        wait_start();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- vlog.f
logic/game_rom_pkg.sv
logic/rom_dwnld.sv
logic/rom_slot.sv
logic/rom_arbiter.sv
logic/game_rom_top.sv
dv/sdram_model.sv
dv/tb_game_rom.sv

//--- Bender.yml
package:
  name: game_rom

sources:
  - files:
      - logic/game_rom_pkg.sv
      - logic/rom_dwnld.sv
      - logic/rom_slot.sv
      - logic/rom_arbiter.sv
      - logic/game_rom_top.sv
  - target: test
    files:
      - dv/sdram_model.sv
      - dv/tb_game_rom.sv
